/* data_cache_top.f */
data_cache_pkg.sv
cache_req_decode.sv
cache_tag_array.sv
cache_lru.sv
cache_data_array.sv
cache_resp_stage.sv
data_cache_top.sv
data_cache_assertions.sv
data_cache_tb.sv

/* data_cache_tb.sv */
// Data cache testbench: clock, reset, stimulus and expected-value table, checks, timeout, summary.
`timescale 1ns/1ns
`default_nettype none

module data_cache_tb;

    localparam int RESET_CYCLES = 4;

    typedef struct packed {
        data_cache_pkg::cache_op_e   op;
        data_cache_pkg::store_size_e size;
        data_cache_pkg::addr_t       addr;
        data_cache_pkg::word_t       wdata;
        data_cache_pkg::block_t      block;
        logic                        exp_hit;
        logic                        exp_dirty;
        data_cache_pkg::word_t       exp_data;
        data_cache_pkg::block_t      exp_block;
    } row_t;

    logic                        clk;
    logic                        arstn;
    logic                        i_req_valid;
    data_cache_pkg::cache_op_e   i_req_op;
    data_cache_pkg::store_size_e i_req_size;
    data_cache_pkg::addr_t       i_req_addr;
    data_cache_pkg::word_t       i_req_wdata;
    data_cache_pkg::block_t      i_req_block;
    logic                        o_resp_valid;
    logic                        o_hit;
    logic                        o_dirty;
    data_cache_pkg::word_t       o_data;
    data_cache_pkg::block_t      o_block;

    row_t   table_q [$];
    integer seed = 47146;
    int     errors = 0;
    int     checks = 0;
    int     cycle_count = 0;
    int     timeout_limit = 0;
    logic   table_ready = 1'b0;

    data_cache_top UUT (
        .clk          (clk),
        .arstn        (arstn),
        .i_req_valid  (i_req_valid),
        .i_req_op     (i_req_op),
        .i_req_size   (i_req_size),
        .i_req_addr   (i_req_addr),
        .i_req_wdata  (i_req_wdata),
        .i_req_block  (i_req_block),
        .o_resp_valid (o_resp_valid),
        .o_hit        (o_hit),
        .o_dirty      (o_dirty),
        .o_data       (o_data),
        .o_block      (o_block)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ------------------------------------------------------------------
    // Reference helpers.
    // ------------------------------------------------------------------
    function automatic data_cache_pkg::addr_t make_addr(
        input data_cache_pkg::tag_t   tag,
        input data_cache_pkg::index_t index,
        input int                     offset,
        input int                     byte_off
    );
        return {tag, index, data_cache_pkg::offset_t'(offset), 2'(byte_off)};
    endfunction

    function automatic data_cache_pkg::word_t word_of(input data_cache_pkg::block_t blk,
                                                      input int off);
        return blk[32*off +: 32];
    endfunction

    // Store merge with natural alignment of half-words and words.
    function automatic data_cache_pkg::block_t merge_store(
        input data_cache_pkg::block_t      blk,
        input int                          off,
        input int                          boff,
        input data_cache_pkg::store_size_e size,
        input data_cache_pkg::word_t       wdata
    );
        data_cache_pkg::word_t w;
        w = word_of(blk, off);
        case (size)
            data_cache_pkg::SZ_BYTE: w[8*boff +: 8] = wdata[7:0];
            data_cache_pkg::SZ_HALF: w[16*(boff/2) +: 16] = wdata[15:0];
            default: w = wdata;
        endcase
        blk[32*off +: 32] = w;
        return blk;
    endfunction

    function automatic data_cache_pkg::block_t random_block();
        data_cache_pkg::block_t blk;
        for (int i = 0; i < data_cache_pkg::BLOCK_WORDS; i++) begin
            blk[32*i +: 32] = $random(seed);
        end
        return blk;
    endfunction

    task automatic add_row(
        input data_cache_pkg::cache_op_e   op,
        input data_cache_pkg::store_size_e size,
        input data_cache_pkg::addr_t       addr,
        input data_cache_pkg::word_t       wdata,
        input data_cache_pkg::block_t      block,
        input logic                        hit,
        input logic                        dirty,
        input data_cache_pkg::word_t       data,
        input data_cache_pkg::block_t      exp_block
    );
        table_q.push_back(row_t'{op, size, addr, wdata, block, hit, dirty, data, exp_block});
    endtask

    // ------------------------------------------------------------------
    // Stimulus table.
    // ------------------------------------------------------------------
    task automatic fill_table();
        data_cache_pkg::block_t blk_t1;
        data_cache_pkg::block_t blk_u [5];
        data_cache_pkg::block_t cur;
        data_cache_pkg::tag_t   tag_u [5];
        // Refill data is drawn before any expected value.
        blk_t1 = random_block();
        for (int i = 0; i < 5; i++) begin
            blk_u[i] = random_block();
            tag_u[i] = data_cache_pkg::tag_t'(24'h0002A0 + i);
        end
        // Cold load and store misses in set 5.
        add_row(data_cache_pkg::OP_LOAD, data_cache_pkg::SZ_WORD,
                make_addr(24'h000AAA, 4'd5, 1, 0), '0, '0, 1'b0, 1'b0, '0, '0);
        add_row(data_cache_pkg::OP_STORE, data_cache_pkg::SZ_WORD,
                make_addr(24'h000AAA, 4'd5, 1, 0), 32'h12345678, '0, 1'b0, 1'b0, '0, '0);
        add_row(data_cache_pkg::OP_LOAD, data_cache_pkg::SZ_WORD,
                make_addr(24'h000AAA, 4'd5, 1, 0), '0, '0, 1'b0, 1'b0, '0, '0);
        // Refill of set 3, then every word back.
        add_row(data_cache_pkg::OP_REFILL, data_cache_pkg::SZ_WORD,
                make_addr(24'h000111, 4'd3, 0, 0), '0, blk_t1, 1'b0, 1'b0, '0, '0);
        cur = blk_t1;
        for (int o = 0; o < 4; o++) begin
            add_row(data_cache_pkg::OP_LOAD, data_cache_pkg::SZ_WORD,
                    make_addr(24'h000111, 4'd3, o, 0), '0, '0, 1'b1, 1'b0, word_of(cur, o), '0);
        end
        // Byte, misaligned half-word and misaligned word stores.
        add_row(data_cache_pkg::OP_STORE, data_cache_pkg::SZ_BYTE,
                make_addr(24'h000111, 4'd3, 1, 2), 32'h000000A5, '0, 1'b1, 1'b0, '0, '0);
        cur = merge_store(cur, 1, 2, data_cache_pkg::SZ_BYTE, 32'h000000A5);
        add_row(data_cache_pkg::OP_STORE, data_cache_pkg::SZ_HALF,
                make_addr(24'h000111, 4'd3, 2, 3), 32'h0000BEEF, '0, 1'b1, 1'b1, '0, '0);
        cur = merge_store(cur, 2, 3, data_cache_pkg::SZ_HALF, 32'h0000BEEF);
        add_row(data_cache_pkg::OP_STORE, data_cache_pkg::SZ_WORD,
                make_addr(24'h000111, 4'd3, 3, 1), 32'hCAFEF00D, '0, 1'b1, 1'b1, '0, '0);
        cur = merge_store(cur, 3, 1, data_cache_pkg::SZ_WORD, 32'hCAFEF00D);
        for (int o = 1; o < 4; o++) begin
            add_row(data_cache_pkg::OP_LOAD, data_cache_pkg::SZ_WORD,
                    make_addr(24'h000111, 4'd3, o, 0), '0, '0, 1'b1, 1'b1, word_of(cur, o), '0);
        end
        // Set 7 fills ways in order, the second tag gets dirty.
        for (int i = 0; i < 2; i++) begin
            add_row(data_cache_pkg::OP_REFILL, data_cache_pkg::SZ_WORD,
                    make_addr(tag_u[i], 4'd7, 0, 0), '0, blk_u[i], 1'b0, 1'b0, '0, '0);
        end
        cur = blk_u[1];
        add_row(data_cache_pkg::OP_STORE, data_cache_pkg::SZ_WORD,
                make_addr(tag_u[1], 4'd7, 2, 0), 32'h11112222, '0, 1'b1, 1'b0, '0, '0);
        cur = merge_store(cur, 2, 0, data_cache_pkg::SZ_WORD, 32'h11112222);
        add_row(data_cache_pkg::OP_STORE, data_cache_pkg::SZ_BYTE,
                make_addr(tag_u[1], 4'd7, 0, 3), 32'h00000077, '0, 1'b1, 1'b1, '0, '0);
        cur = merge_store(cur, 0, 3, data_cache_pkg::SZ_BYTE, 32'h00000077);
        for (int i = 2; i < 4; i++) begin
            add_row(data_cache_pkg::OP_REFILL, data_cache_pkg::SZ_WORD,
                    make_addr(tag_u[i], 4'd7, 0, 0), '0, blk_u[i], 1'b0, 1'b0, '0, '0);
        end
        // Touch the first tag so the second becomes oldest.
        add_row(data_cache_pkg::OP_LOAD, data_cache_pkg::SZ_WORD, make_addr(tag_u[0], 4'd7, 0, 0),
                '0, '0, 1'b1, 1'b0, word_of(blk_u[0], 0), '0);
        add_row(data_cache_pkg::OP_REFILL, data_cache_pkg::SZ_WORD,
                make_addr(tag_u[4], 4'd7, 0, 0), '0, blk_u[4], 1'b0, 1'b1, '0, cur);
        add_row(data_cache_pkg::OP_LOAD, data_cache_pkg::SZ_WORD,
                make_addr(tag_u[1], 4'd7, 2, 0), '0, '0, 1'b0, 1'b0, '0, '0);
        add_row(data_cache_pkg::OP_LOAD, data_cache_pkg::SZ_WORD, make_addr(tag_u[4], 4'd7, 3, 0),
                '0, '0, 1'b1, 1'b0, word_of(blk_u[4], 3), '0);
    endtask

    task automatic apply_row(input int r);
        i_req_valid = 1'b1;
        i_req_op    = table_q[r].op;
        i_req_size  = table_q[r].size;
        i_req_addr  = table_q[r].addr;
        i_req_wdata = table_q[r].wdata;
        i_req_block = table_q[r].block;
    endtask

    task automatic check_row(input int r);
        row_t row;
        row = table_q[r];
        checks++;
        assert (o_resp_valid === 1'b1) else begin
            $display("Row %0d: no response strobe one cycle after the request", r);
            errors++;
        end
        assert (o_hit === row.exp_hit) else begin
            $display("ERR row %0d o_hit expected %h actual %h", r, row.exp_hit, o_hit);
            errors++;
        end
        assert (o_dirty === row.exp_dirty) else begin
            $display("ERR row %0d o_dirty expected %h actual %h", r, row.exp_dirty, o_dirty);
            errors++;
        end
        assert (o_data === row.exp_data) else begin
            $display("ERR row %0d o_data expected %h actual %h", r, row.exp_data, o_data);
            errors++;
        end
        assert (o_block === row.exp_block) else begin
            $display("ERR row %0d o_block expected %h actual %h", r, row.exp_block, o_block);
            errors++;
        end
    endtask

    // ------------------------------------------------------------------
    // Main sequence.
    // ------------------------------------------------------------------
    initial begin
        arstn       = 1'b0;
        i_req_valid = 1'b0;
        i_req_op    = data_cache_pkg::OP_LOAD;
        i_req_size  = data_cache_pkg::SZ_WORD;
        i_req_addr  = '0;
        i_req_wdata = '0;
        i_req_block = '0;
        fill_table();
        timeout_limit = RESET_CYCLES + table_q.size() + 20;
        table_ready   = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arstn = 1'b1;
        // Each pass checks the previous row and drives the next one.
        for (int r = 0; r <= table_q.size(); r++) begin
            @(negedge clk);
            if (r > 0) begin
                check_row(r - 1);
            end
            if (r < table_q.size()) begin
                apply_row(r);
            end else begin
                i_req_valid = 1'b0;
            end
        end
        // Let the idle strobe after the last request reach the assertions.
        repeat (2) @(negedge clk);
        errors = errors + UUT.u_assertions.fail_count;
        $display("Rows checked: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // Run limit.
    initial begin
        wait (table_ready);
        while (cycle_count < timeout_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", timeout_limit);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

/* data_cache_assertions.sv */
// Concurrent assertions on the data cache top-level ports and their bind to the top.
`timescale 1ns/1ns
`default_nettype none

module data_cache_assertions (
    input logic                      clk,
    input logic                      arstn,
    input logic                      i_req_valid,
    input data_cache_pkg::cache_op_e i_req_op,
    input logic                      o_resp_valid,
    input logic                      o_hit,
    input logic                      o_dirty,
    input data_cache_pkg::block_t    o_block
);

    int fail_count = 0;

    // ------------------------------------------------------------------
    // Response strobe timing.
    // ------------------------------------------------------------------
    resp_after_req: assert property (@(posedge clk) disable iff (!arstn)
        i_req_valid |=> o_resp_valid)
        else begin
            $error("Response strobe missing one cycle after a request");
            fail_count++;
        end

    no_resp_without_req: assert property (@(posedge clk) disable iff (!arstn)
        !i_req_valid |=> !o_resp_valid)
        else begin
            $error("Response strobe without a request");
            fail_count++;
        end

    // Idle outputs stay quiet.
    idle_flags_low: assert property (@(posedge clk) disable iff (!arstn)
        !o_resp_valid |-> (!o_hit && !o_dirty))
        else begin
            $error("Hit or dirty high without a response");
            fail_count++;
        end

    block_zero_off_refill: assert property (@(posedge clk) disable iff (!arstn)
        (i_req_valid && i_req_op != data_cache_pkg::OP_REFILL) |=> (o_block == '0))
        else begin
            $error("Block output nonzero on a response other than a refill");
            fail_count++;
        end

endmodule

bind data_cache_top data_cache_assertions u_assertions (
    .clk          (clk),
    .arstn        (arstn),
    .i_req_valid  (i_req_valid),
    .i_req_op     (i_req_op),
    .o_resp_valid (o_resp_valid),
    .o_hit        (o_hit),
    .o_dirty      (o_dirty),
    .o_block      (o_block)
);

`default_nettype wire

/* data_cache_top.sv */
// Data cache top level: request decode, tag, LRU and data arrays, response stage.
`timescale 1ns/1ns
`default_nettype none

module data_cache_top (
    input  logic                        clk,
    input  logic                        arstn,

    // Request.
    input  logic                        i_req_valid,
    input  data_cache_pkg::cache_op_e   i_req_op,
    input  data_cache_pkg::store_size_e i_req_size,
    input  data_cache_pkg::addr_t       i_req_addr,
    input  data_cache_pkg::word_t       i_req_wdata,
    input  data_cache_pkg::block_t      i_req_block,

    // Response, one cycle after the request.
    output logic                        o_resp_valid,
    output logic                        o_hit,
    output logic                        o_dirty,
    output data_cache_pkg::word_t       o_data,
    output data_cache_pkg::block_t      o_block
);

    // ------------------------------------------------------------------
    // Internal connections.
    // ------------------------------------------------------------------
    data_cache_pkg::cache_req_t req;
    data_cache_pkg::lookup_t    lookup;
    data_cache_pkg::way_t       victim_way;
    data_cache_pkg::block_t     rd_block;
    logic                       victim_dirty;
    logic                       victim_valid;

    cache_req_decode u_req_decode (
        .i_req_valid (i_req_valid),
        .i_req_op    (i_req_op),
        .i_req_size  (i_req_size),
        .i_req_addr  (i_req_addr),
        .i_req_wdata (i_req_wdata),
        .i_req_block (i_req_block),
        .o_req       (req)
    );

    cache_tag_array u_tag_array (
        .clk            (clk),
        .arstn          (arstn),
        .i_req          (req),
        .i_victim_way   (victim_way),
        .o_lookup       (lookup),
        .o_victim_dirty (victim_dirty),
        .o_victim_valid (victim_valid)
    );

    cache_lru u_lru (
        .clk          (clk),
        .arstn        (arstn),
        .i_req        (req),
        .i_lookup     (lookup),
        .o_victim_way (victim_way)
    );

    cache_data_array u_data_array (
        .clk          (clk),
        .i_req        (req),
        .i_lookup     (lookup),
        .i_victim_way (victim_way),
        .o_block      (rd_block)
    );

    cache_resp_stage u_resp_stage (
        .clk            (clk),
        .arstn          (arstn),
        .i_req          (req),
        .i_lookup       (lookup),
        .i_block        (rd_block),
        .i_victim_dirty (victim_dirty),
        .i_victim_valid (victim_valid),
        .o_resp_valid   (o_resp_valid),
        .o_hit          (o_hit),
        .o_dirty        (o_dirty),
        .o_data         (o_data),
        .o_block        (o_block)
    );

endmodule

`default_nettype wire

/* cache_resp_stage.sv */
// Response stage: word select, response rules and the registered outputs.
`timescale 1ns/1ns
`default_nettype none

module cache_resp_stage (
    input  logic                       clk,
    input  logic                       arstn,
    input  data_cache_pkg::cache_req_t i_req,
    input  data_cache_pkg::lookup_t    i_lookup,
    input  data_cache_pkg::block_t     i_block,
    input  logic                       i_victim_dirty,
    input  logic                       i_victim_valid,
    output logic                       o_resp_valid,
    output logic                       o_hit,
    output logic                       o_dirty,
    output data_cache_pkg::word_t      o_data,
    output data_cache_pkg::block_t     o_block
);

    data_cache_pkg::word_t  sel_word;
    data_cache_pkg::word_t  next_data;
    data_cache_pkg::block_t next_block;
    logic                   next_hit;
    logic                   next_dirty;
    logic                   is_load;
    logic                   is_refill;

    assign sel_word  = i_block[i_req.offset * data_cache_pkg::WORD_WIDTH
                               +: data_cache_pkg::WORD_WIDTH];
    assign is_load   = i_req.valid && (i_req.op == data_cache_pkg::OP_LOAD);
    assign is_refill = i_req.valid && (i_req.op == data_cache_pkg::OP_REFILL);

    // Response rules. Everything reads zero without a request.
    assign next_hit   = i_req.valid && i_lookup.hit;
    assign next_dirty = is_refill ? i_victim_dirty : (i_req.valid && i_lookup.dirty);
    assign next_data  = (is_load && i_lookup.hit) ? sel_word : '0;
    assign next_block = (is_refill && i_victim_valid) ? i_block : '0;

    // ------------------------------------------------------------------
    // Output registers.
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            o_resp_valid <= 1'b0;
            o_hit        <= 1'b0;
            o_dirty      <= 1'b0;
        end else begin
            o_resp_valid <= i_req.valid;
            o_hit        <= next_hit;
            o_dirty      <= next_dirty;
        end
    end

    always_ff @(posedge clk) begin
        o_data  <= next_data;
        o_block <= next_block;
    end

endmodule

`default_nettype wire

/* cache_data_array.sv */
// Block storage with byte-enable store writes and whole-block refill.
`timescale 1ns/1ns
`default_nettype none

module cache_data_array (
    input  logic                       clk,
    input  data_cache_pkg::cache_req_t i_req,
    input  data_cache_pkg::lookup_t    i_lookup,
    input  data_cache_pkg::way_t       i_victim_way,
    output data_cache_pkg::block_t     o_block
);

    data_cache_pkg::block_t data_mem [data_cache_pkg::SET_COUNT][data_cache_pkg::WAYS];

    data_cache_pkg::way_t   read_way;
    logic                   store_hit;
    logic                   refill;

    assign refill    = i_req.valid && (i_req.op == data_cache_pkg::OP_REFILL);
    assign store_hit = i_req.valid && (i_req.op == data_cache_pkg::OP_STORE) && i_lookup.hit;

    // ------------------------------------------------------------------
    // Read side, old contents of the way about to be written.
    // ------------------------------------------------------------------
    assign read_way = (i_req.op == data_cache_pkg::OP_REFILL) ? i_victim_way : i_lookup.hit_way;
    assign o_block  = data_mem[i_req.index][read_way];

    // ------------------------------------------------------------------
    // Write side.
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (refill) begin
            data_mem[i_req.index][i_victim_way] <= i_req.block;
        end else if (store_hit) begin
            // Only the enabled byte lanes change.
            for (int b = 0; b < data_cache_pkg::BYTES_PER_BLOCK; b++) begin
                if (i_req.byte_en[b]) begin
                    data_mem[i_req.index][i_lookup.hit_way][8*b +: 8] <= i_req.wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* cache_lru.sv */
// Per-set way ages, victim selection and age update on each touch.
`timescale 1ns/1ns
`default_nettype none

module cache_lru (
    input  logic                       clk,
    input  logic                       arstn,
    input  data_cache_pkg::cache_req_t i_req,
    input  data_cache_pkg::lookup_t    i_lookup,
    output data_cache_pkg::way_t       o_victim_way
);

    data_cache_pkg::age_t age_q [data_cache_pkg::SET_COUNT][data_cache_pkg::WAYS];

    logic                 touch_en;
    data_cache_pkg::way_t touch_way;
    data_cache_pkg::age_t touch_age;

    // ------------------------------------------------------------------
    // Victim is the way whose age is zero.
    // ------------------------------------------------------------------
    always_comb begin
        o_victim_way = '0;
        for (int w = 0; w < data_cache_pkg::WAYS; w++) begin
            if (age_q[i_req.index][w] == '0) begin
                o_victim_way = data_cache_pkg::way_t'(w);
            end
        end
    end

    // Hits on load or store touch the hit way, a refill touches the victim.
    always_comb begin
        touch_en  = 1'b0;
        touch_way = i_lookup.hit_way;
        if (i_req.valid) begin
            case (i_req.op)
                data_cache_pkg::OP_LOAD,
                data_cache_pkg::OP_STORE: touch_en = i_lookup.hit;
                data_cache_pkg::OP_REFILL: begin
                    touch_en  = 1'b1;
                    touch_way = o_victim_way;
                end
                default: touch_en = 1'b0;
            endcase
        end
    end

    assign touch_age = age_q[i_req.index][touch_way];

    // ------------------------------------------------------------------
    // Age update.
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            for (int s = 0; s < data_cache_pkg::SET_COUNT; s++) begin
                for (int w = 0; w < data_cache_pkg::WAYS; w++) begin
                    age_q[s][w] <= data_cache_pkg::age_t'(w);
                end
            end
        end else if (touch_en) begin
            for (int w = 0; w < data_cache_pkg::WAYS; w++) begin
                if (data_cache_pkg::way_t'(w) == touch_way) begin
                    age_q[i_req.index][w] <= data_cache_pkg::age_t'(data_cache_pkg::WAYS - 1);
                end else if (age_q[i_req.index][w] > touch_age) begin
                    age_q[i_req.index][w] <= age_q[i_req.index][w] - 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* cache_tag_array.sv */
// Tag, valid and dirty storage with per-way hit detection and victim status.
`timescale 1ns/1ns
`default_nettype none

module cache_tag_array (
    input  logic                       clk,
    input  logic                       arstn,
    input  data_cache_pkg::cache_req_t i_req,
    input  data_cache_pkg::way_t       i_victim_way,
    output data_cache_pkg::lookup_t    o_lookup,
    output logic                       o_victim_dirty,
    output logic                       o_victim_valid
);

    // ------------------------------------------------------------------
    // Storage.
    // ------------------------------------------------------------------
    data_cache_pkg::tag_t                tag_mem [data_cache_pkg::SET_COUNT][data_cache_pkg::WAYS];
    logic [data_cache_pkg::WAYS-1:0]     valid_q [data_cache_pkg::SET_COUNT];
    logic [data_cache_pkg::WAYS-1:0]     dirty_q [data_cache_pkg::SET_COUNT];

    logic [data_cache_pkg::WAYS-1:0]     hit_vec;
    data_cache_pkg::way_t                hit_way;
    logic                                store_hit;
    logic                                refill;

    // ------------------------------------------------------------------
    // Lookup.
    // ------------------------------------------------------------------
    always_comb begin
        for (int w = 0; w < data_cache_pkg::WAYS; w++) begin
            hit_vec[w] = valid_q[i_req.index][w] && (tag_mem[i_req.index][w] == i_req.tag);
        end
    end

    // Lowest matching way wins.
    always_comb begin
        hit_way = '0;
        for (int w = data_cache_pkg::WAYS - 1; w >= 0; w--) begin
            if (hit_vec[w]) begin
                hit_way = data_cache_pkg::way_t'(w);
            end
        end
    end

    assign o_lookup.hit     = |hit_vec;
    assign o_lookup.hit_way = hit_way;
    assign o_lookup.dirty   = o_lookup.hit && dirty_q[i_req.index][hit_way];

    assign o_victim_dirty = dirty_q[i_req.index][i_victim_way];
    assign o_victim_valid = valid_q[i_req.index][i_victim_way];

    assign store_hit = i_req.valid && (i_req.op == data_cache_pkg::OP_STORE) && o_lookup.hit;
    assign refill    = i_req.valid && (i_req.op == data_cache_pkg::OP_REFILL);

    // ------------------------------------------------------------------
    // Update.
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (refill) begin
            tag_mem[i_req.index][i_victim_way] <= i_req.tag;
        end
    end

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            for (int s = 0; s < data_cache_pkg::SET_COUNT; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end else if (refill) begin
            valid_q[i_req.index][i_victim_way] <= 1'b1;
            dirty_q[i_req.index][i_victim_way] <= 1'b0;
        end else if (store_hit) begin
            dirty_q[i_req.index][hit_way] <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* cache_req_decode.sv */
// Request decode: address fields, store byte-enable mask and lane-replicated store data.
`timescale 1ns/1ns
`default_nettype none

module cache_req_decode (
    input  logic                        i_req_valid,
    input  data_cache_pkg::cache_op_e   i_req_op,
    input  data_cache_pkg::store_size_e i_req_size,
    input  data_cache_pkg::addr_t       i_req_addr,
    input  data_cache_pkg::word_t       i_req_wdata,
    input  data_cache_pkg::block_t      i_req_block,
    output data_cache_pkg::cache_req_t  o_req
);

    logic [data_cache_pkg::BYTE_OFF_WIDTH-1:0] byte_off;
    logic [data_cache_pkg::BYTES_PER_WORD-1:0] word_be;
    data_cache_pkg::word_t                     lane_word;

    assign byte_off = i_req_addr[data_cache_pkg::BYTE_OFF_WIDTH-1:0];

    // Byte lanes within the word, aligned down to the natural boundary.
    always_comb begin
        case (i_req_size)
            data_cache_pkg::SZ_BYTE: begin
                word_be   = 4'b0001 << byte_off;
                lane_word = {4{i_req_wdata[7:0]}};
            end
            data_cache_pkg::SZ_HALF: begin
                word_be   = 4'b0011 << {byte_off[1], 1'b0};
                lane_word = {2{i_req_wdata[15:0]}};
            end
            default: begin
                word_be   = 4'b1111;
                lane_word = i_req_wdata;
            end
        endcase
    end

    // Address split and block-wide fields.
    always_comb begin
        o_req.valid   = i_req_valid;
        o_req.op      = i_req_op;
        o_req.tag     = i_req_addr[data_cache_pkg::ADDR_WIDTH-1 -: data_cache_pkg::TAG_WIDTH];
        o_req.index   = i_req_addr[data_cache_pkg::BYTE_OFF_WIDTH + data_cache_pkg::OFFSET_WIDTH
                                   +: data_cache_pkg::INDEX_WIDTH];
        o_req.offset  = i_req_addr[data_cache_pkg::BYTE_OFF_WIDTH +: data_cache_pkg::OFFSET_WIDTH];
        o_req.byte_en = data_cache_pkg::byte_en_t'(word_be)
                        << (o_req.offset * data_cache_pkg::BYTES_PER_WORD);
        o_req.wdata   = {data_cache_pkg::BLOCK_WORDS{lane_word}};
        o_req.block   = i_req_block;
    end

endmodule

`default_nettype wire

/* data_cache_pkg.sv */
// Cache geometry, field widths, vector types, request enums and the request and lookup structs.
`default_nettype none

package data_cache_pkg;

    // ------------------------------------------------------------------
    // Geometry.
    // ------------------------------------------------------------------
    localparam int ADDR_WIDTH  = 32;
    localparam int WORD_WIDTH  = 32;
    localparam int SET_COUNT   = 16;
    localparam int WAYS        = 4;
    localparam int BLOCK_WORDS = 4;

    // Derived widths.
    localparam int BYTES_PER_WORD  = WORD_WIDTH / 8;
    localparam int BLOCK_WIDTH     = WORD_WIDTH * BLOCK_WORDS;
    localparam int BYTES_PER_BLOCK = BLOCK_WIDTH / 8;
    localparam int INDEX_WIDTH     = $clog2(SET_COUNT);
    localparam int OFFSET_WIDTH    = $clog2(BLOCK_WORDS);
    localparam int BYTE_OFF_WIDTH  = $clog2(BYTES_PER_WORD);
    localparam int TAG_WIDTH       = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH - BYTE_OFF_WIDTH;
    localparam int WAY_WIDTH       = $clog2(WAYS);

    // ------------------------------------------------------------------
    // Vector types.
    // ------------------------------------------------------------------
    typedef logic [ADDR_WIDTH-1:0]      addr_t;
    typedef logic [WORD_WIDTH-1:0]      word_t;
    typedef logic [BLOCK_WIDTH-1:0]     block_t;
    typedef logic [TAG_WIDTH-1:0]       tag_t;
    typedef logic [INDEX_WIDTH-1:0]     index_t;
    typedef logic [OFFSET_WIDTH-1:0]    offset_t;
    typedef logic [WAY_WIDTH-1:0]       way_t;
    typedef logic [WAY_WIDTH-1:0]       age_t;    // 0 is the oldest way.
    typedef logic [BYTES_PER_BLOCK-1:0] byte_en_t;

    // Request kind.
    typedef enum logic [1:0] {
        OP_LOAD   = 2'd0,
        OP_STORE  = 2'd1,
        OP_REFILL = 2'd2
    } cache_op_e;

    // Store size.
    typedef enum logic [1:0] {
        SZ_BYTE = 2'd0,
        SZ_HALF = 2'd1,
        SZ_WORD = 2'd2
    } store_size_e;

    // Decoded request, shared by all arrays.
    typedef struct packed {
        logic      valid;
        cache_op_e op;
        tag_t      tag;
        index_t    index;
        offset_t   offset;
        byte_en_t  byte_en;
        block_t    wdata;    // Store data replicated into every lane.
        block_t    block;    // Refill data.
    } cache_req_t;

    // Tag lookup result.
    typedef struct packed {
        logic hit;
        way_t hit_way;
        logic dirty;
    } lookup_t;

endpackage

`default_nettype wire
